// File: vlog.f
hw/axi_iso_pkg.sv
hw/iso_ctrl.sv
hw/pending_tracker.sv
hw/bus_gate.sv
hw/axi_isolate_top.sv
tests/axi_isolate_chk.sv
tests/tb_axi_isolate.sv

// File: Makefile
TOP = tb_axi_isolate

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f vlog.f --top-module $(TOP)
	verilator --lint-only hw/axi_iso_pkg.sv hw/iso_ctrl.sv hw/pending_tracker.sv \
		hw/bus_gate.sv hw/axi_isolate_top.sv --top-module axi_isolate_top

clean:
	rm -rf obj_dir

// File: tests/tb_axi_isolate.sv
`default_nettype none

module tb_axi_isolate;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_TXN     = 200;
  localparam int TIMEOUT_CYC = NUM_TXN * 40;
  // Batches larger than the pending limit force back-pressure
  localparam int MAX_BATCH   = axi_iso_pkg::NUM_PENDING + 2;

  logic clk_i;
  logic rst_i;
  logic isolate_i;
  logic isolated_o;

  axi_iso_pkg::axi_req_t  slv_req;
  axi_iso_pkg::axi_resp_t slv_resp_o;
  axi_iso_pkg::axi_req_t  mst_req;
  axi_iso_pkg::axi_resp_t mst_resp = '0;

  int seed;
  int err_cnt;
  int cycle_cnt;
  logic traffic_done;

  // Downstream memory and the expected image kept by the driver
  logic [31:0] mem [0:255];
  logic [31:0] ref_mem [0:255];

  // Current batch, all of it kept in flight at once
  int         bat_n;
  logic [3:0] bat_id [0:MAX_BATCH-1];
  logic [7:0] bat_idx [0:MAX_BATCH-1];
  logic [7:0] bat_len [0:MAX_BATCH-1];

  // Model bookkeeping
  logic [7:0] wr_idx_q [$];
  logic [3:0] wr_id_q [$];
  logic [3:0] b_id_q [$];
  logic [7:0] rd_idx_q [$];
  logic [3:0] rd_id_q [$];
  logic [7:0] rd_len_q [$];
  logic [7:0] w_beat;
  logic [7:0] r_beat;
  logic       b_busy;
  logic       r_busy;
  int aw_open;
  int wb_open;
  int ar_open;

  axi_isolate_top UUT (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .slv_req_i  (slv_req),
    .slv_resp_o (slv_resp_o),
    .mst_req_o  (mst_req),
    .mst_resp_i (mst_resp),
    .isolate_i  (isolate_i),
    .isolated_o (isolated_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Helpers and compare tasks
  //////////////////////////////

  function automatic int rand_below(input int n);
    return ($random(seed) & 32'h7fffffff) % n;
  endfunction

  // Fill value spans the whole word address
  function automatic logic [31:0] fill_word(input int i);
    return 32'hC0DE0000 ^ (32'(i) * 32'h00010101);
  endfunction

  task automatic report_fail(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_r(input axi_iso_pkg::r_chan_t exp, input axi_iso_pkg::r_chan_t got);
    if (got !== exp) begin
      report_fail($sformatf("FAIL slv_resp_o.r expected 0x%h got 0x%h", exp, got));
    end
  endtask

  task automatic check_b(input axi_iso_pkg::b_chan_t exp, input axi_iso_pkg::b_chan_t got);
    if (got !== exp) begin
      report_fail($sformatf("FAIL slv_resp_o.b expected 0x%h got 0x%h", exp, got));
    end
  endtask

  task automatic check_req(input string name, input axi_iso_pkg::axi_req_t exp,
                           input axi_iso_pkg::axi_req_t got);
    if (got !== exp) begin
      report_fail($sformatf("FAIL %s expected 0x%h got 0x%h", name, exp, got));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      report_fail($sformatf("FAIL %s expected 0x%h got 0x%h", name, exp, got));
    end
  endtask

  //////////////////////////////
  // Upstream driver
  //////////////////////////////

  // Back to back AWs, stalls once the pending limit is reached
  task automatic issue_aw();
    int k;
    for (k = 0; k < bat_n; k++) begin
      slv_req.aw.id    <= bat_id[k];
      slv_req.aw.addr  <= {22'd0, bat_idx[k], 2'b00};
      slv_req.aw.len   <= bat_len[k];
      slv_req.aw.size  <= 3'd2;
      slv_req.aw.burst <= 2'b01;
      slv_req.aw_valid <= 1'b1;
      @(posedge clk_i);
      while (!slv_resp_o.aw_ready) @(posedge clk_i);
    end
    slv_req.aw_valid <= 1'b0;
    slv_req.aw       <= '0;
  endtask

  // W bursts in AW order
  task automatic send_w();
    int k;
    logic [31:0] data;
    logic [7:0]  beat;
    for (k = 0; k < bat_n; k++) begin
      for (beat = 8'd0; beat <= bat_len[k]; beat++) begin
        data = $random(seed);
        slv_req.w.data  <= data;
        slv_req.w.strb  <= '1;
        slv_req.w.last  <= (beat == bat_len[k]);
        slv_req.w_valid <= 1'b1;
        @(posedge clk_i);
        while (!slv_resp_o.w_ready) @(posedge clk_i);
        ref_mem[bat_idx[k] + beat] = data;
      end
    end
    slv_req.w_valid <= 1'b0;
    slv_req.w       <= '0;
  endtask

  // Responses come back in issue order
  task automatic collect_b();
    int k;
    axi_iso_pkg::b_chan_t exp_b;
    for (k = 0; k < bat_n; k++) begin
      @(posedge clk_i);
      while (!slv_resp_o.b_valid) @(posedge clk_i);
      exp_b.id   = bat_id[k];
      exp_b.resp = 2'b00;
      check_b(exp_b, slv_resp_o.b);
    end
  endtask

  task automatic issue_ar();
    int k;
    for (k = 0; k < bat_n; k++) begin
      slv_req.ar.id    <= bat_id[k];
      slv_req.ar.addr  <= {22'd0, bat_idx[k], 2'b00};
      slv_req.ar.len   <= bat_len[k];
      slv_req.ar.size  <= 3'd2;
      slv_req.ar.burst <= 2'b01;
      slv_req.ar_valid <= 1'b1;
      @(posedge clk_i);
      while (!slv_resp_o.ar_ready) @(posedge clk_i);
    end
    slv_req.ar_valid <= 1'b0;
    slv_req.ar       <= '0;
  endtask

  task automatic collect_r();
    int k;
    axi_iso_pkg::r_chan_t exp_r;
    logic [7:0] beat;
    for (k = 0; k < bat_n; k++) begin
      for (beat = 8'd0; beat <= bat_len[k]; beat++) begin
        @(posedge clk_i);
        while (!slv_resp_o.r_valid) @(posedge clk_i);
        exp_r.id   = bat_id[k];
        exp_r.data = ref_mem[bat_idx[k] + beat];
        exp_r.resp = 2'b00;
        exp_r.last = (beat == bat_len[k]);
        check_r(exp_r, slv_resp_o.r);
      end
    end
  endtask

  // Batches are all writes or all reads, so ref_mem stays valid for reads
  task automatic run_traffic();
    int txn;
    int k;
    txn = 0;
    while (txn < NUM_TXN) begin
      repeat (rand_below(4)) @(posedge clk_i);
      bat_n = 1 + rand_below(MAX_BATCH);
      for (k = 0; k < bat_n; k++) begin
        bat_idx[k] = 8'(rand_below(252));
        bat_len[k] = 8'(rand_below(4));
        bat_id[k]  = 4'(rand_below(16));
      end
      if (rand_below(2) == 1) begin
        fork
          issue_aw();
          send_w();
          collect_b();
        join
      end else begin
        fork
          issue_ar();
          collect_r();
        join
      end
      txn += bat_n;
    end
    traffic_done = 1'b1;
  endtask

  // isolated_o must stay up for every cycle of the window
  task automatic expect_isolated(input int cycles);
    repeat (cycles) begin
      @(posedge clk_i);
      check_bit("isolated_o", 1'b1, isolated_o);
    end
  endtask

  // isolated_o still high for one cycle, then low
  task automatic release_isolation();
    isolate_i <= 1'b0;
    @(negedge clk_i);
    check_bit("isolated_o", 1'b1, isolated_o);
    @(negedge clk_i);
    check_bit("isolated_o", 1'b0, isolated_o);
    @(posedge clk_i);
  endtask

  task automatic run_isolation();
    expect_isolated(5);
    release_isolation();
    while (!traffic_done) begin
      repeat (30 + rand_below(60)) @(posedge clk_i);
      isolate_i <= 1'b1;
      @(posedge clk_i);
      while (!isolated_o) @(posedge clk_i);
      expect_isolated(5 + rand_below(16));
      release_isolation();
    end
  endtask

  //////////////////////////////
  // Downstream memory model
  //////////////////////////////

  always @(posedge clk_i) begin
    if (rst_i) begin
      mst_resp <= '0;
      wr_idx_q.delete();
      wr_id_q.delete();
      b_id_q.delete();
      rd_idx_q.delete();
      rd_id_q.delete();
      rd_len_q.delete();
      w_beat  = '0;
      r_beat  = '0;
      aw_open = 0;
      wb_open = 0;
      ar_open = 0;
    end else begin
      mst_resp.aw_ready <= (rand_below(4) != 0);
      mst_resp.w_ready  <= (rand_below(4) != 0);
      mst_resp.ar_ready <= (rand_below(4) != 0);
      // Write address and data
      if (mst_req.aw_valid && mst_resp.aw_ready) begin
        wr_idx_q.push_back(mst_req.aw.addr[9:2]);
        wr_id_q.push_back(mst_req.aw.id);
        aw_open++;
        wb_open++;
      end
      if (mst_req.w_valid && mst_resp.w_ready && wr_idx_q.size() > 0) begin
        mem[wr_idx_q[0] + w_beat] = mst_req.w.data;
        w_beat++;
        if (mst_req.w.last) begin
          b_id_q.push_back(wr_id_q.pop_front());
          void'(wr_idx_q.pop_front());
          w_beat = '0;
          wb_open--;
        end
      end
      // Write response after a random delay
      b_busy = mst_resp.b_valid;
      if (mst_resp.b_valid && mst_req.b_ready) begin
        mst_resp.b_valid <= 1'b0;
        b_busy = 1'b0;
        aw_open--;
      end
      if (!b_busy && b_id_q.size() > 0 && rand_below(2) == 1) begin
        mst_resp.b.id    <= b_id_q.pop_front();
        mst_resp.b.resp  <= 2'b00;
        mst_resp.b_valid <= 1'b1;
      end
      // Read address and data
      if (mst_req.ar_valid && mst_resp.ar_ready) begin
        rd_idx_q.push_back(mst_req.ar.addr[9:2]);
        rd_id_q.push_back(mst_req.ar.id);
        rd_len_q.push_back(mst_req.ar.len);
        ar_open++;
      end
      r_busy = mst_resp.r_valid;
      if (mst_resp.r_valid && mst_req.r_ready) begin
        mst_resp.r_valid <= 1'b0;
        r_busy = 1'b0;
        if (mst_resp.r.last) begin
          void'(rd_idx_q.pop_front());
          void'(rd_id_q.pop_front());
          void'(rd_len_q.pop_front());
          r_beat = '0;
          ar_open--;
        end else begin
          r_beat++;
        end
      end
      if (!r_busy && rd_idx_q.size() > 0 && rand_below(2) == 1) begin
        mst_resp.r.id    <= rd_id_q[0];
        mst_resp.r.data  <= mem[rd_idx_q[0] + r_beat];
        mst_resp.r.resp  <= 2'b00;
        mst_resp.r.last  <= (r_beat == rd_len_q[0]);
        mst_resp.r_valid <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // Monitors and timeout
  //////////////////////////////

  // Sampled mid-cycle, away from the driving edge
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (aw_open > axi_iso_pkg::NUM_PENDING || wb_open > axi_iso_pkg::NUM_PENDING ||
          ar_open > axi_iso_pkg::NUM_PENDING) begin
        report_fail("Open transaction count above the pending limit");
      end
      if (aw_open < 0 || wb_open < 0 || ar_open < 0) begin
        report_fail("Open transaction count went below zero");
      end
      if (isolated_o) begin
        if (aw_open != 0 || wb_open != 0 || ar_open != 0) begin
          report_fail("Port isolated while transactions were still open");
        end
        check_req("mst_req_o", '0, mst_req);
        check_bit("slv_resp_o.aw_ready", 1'b0, slv_resp_o.aw_ready);
        check_bit("slv_resp_o.w_ready", 1'b0, slv_resp_o.w_ready);
        check_bit("slv_resp_o.ar_ready", 1'b0, slv_resp_o.ar_ready);
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      report_fail("Timeout, traffic did not finish within the cycle limit");
    end
  end

  initial begin
    seed         = 8;
    err_cnt      = 0;
    cycle_cnt    = 0;
    traffic_done = 1'b0;
    for (int i = 0; i < 256; i++) begin
      mem[i]     = fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    slv_req   = '0;
    isolate_i = 1'b1;
    rst_i     = 1'b1;
    repeat (10) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    slv_req.b_ready <= 1'b1;
    slv_req.r_ready <= 1'b1;
    fork
      run_traffic();
      run_isolation();
    join
    repeat (10) @(posedge clk_i);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/axi_isolate_chk.sv
`default_nettype none

module axi_isolate_chk (
  input logic                   clk_i,
  input logic                   rst_i,
  input axi_iso_pkg::axi_req_t  mst_req_o,
  input axi_iso_pkg::axi_resp_t mst_resp_i,
  input logic                   isolated_o,
  input axi_iso_pkg::cnt_t      aw_cnt_i,
  input axi_iso_pkg::cnt_t      w_cnt_i,
  input axi_iso_pkg::cnt_t      ar_cnt_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Address valid stays up until accepted downstream
  aw_valid_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (mst_req_o.aw_valid && !mst_resp_i.aw_ready) |=> mst_req_o.aw_valid)
    else $error("Downstream aw_valid dropped before aw_ready");

  ar_valid_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (mst_req_o.ar_valid && !mst_resp_i.ar_ready) |=> mst_req_o.ar_valid)
    else $error("Downstream ar_valid dropped before ar_ready");

  // Isolated port drives nothing downstream
  mute_when_isolated: assert property (@(posedge clk_i) disable iff (rst_i)
    isolated_o |-> (mst_req_o == '0))
    else $error("Downstream request not zero while isolated");

  // A wrapped counter lands above the limit as well
  cnt_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
    (aw_cnt_i <= axi_iso_pkg::cnt_t'(axi_iso_pkg::NUM_PENDING)) &&
    (w_cnt_i <= axi_iso_pkg::cnt_t'(axi_iso_pkg::NUM_PENDING)) &&
    (ar_cnt_i <= axi_iso_pkg::cnt_t'(axi_iso_pkg::NUM_PENDING)))
    else $error("Pending counter out of range");

endmodule

bind axi_isolate_top axi_isolate_chk u_chk (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .mst_req_o  (mst_req_o),
  .mst_resp_i (mst_resp_i),
  .isolated_o (isolated_o),
  .aw_cnt_i   (u_tracker.aw_cnt_q),
  .w_cnt_i    (u_tracker.w_cnt_q),
  .ar_cnt_i   (u_tracker.ar_cnt_q)
);

`default_nettype wire

// File: hw/axi_isolate_top.sv
`default_nettype none

module axi_isolate_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  axi_iso_pkg::axi_req_t  slv_req_i,
  output axi_iso_pkg::axi_resp_t slv_resp_o,
  output axi_iso_pkg::axi_req_t  mst_req_o,
  input  axi_iso_pkg::axi_resp_t mst_resp_i,
  input  logic                   isolate_i,
  output logic                   isolated_o
);

  axi_iso_pkg::pend_status_t status;
  axi_iso_pkg::gate_ctrl_t   gate;

  // Counts what actually crossed the downstream port
  pending_tracker u_tracker (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .mst_req_i  (mst_req_o),
    .mst_resp_i (mst_resp_i),
    .status_o   (status)
  );

  // AW and AR isolation FSMs
  iso_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .isolate_i      (isolate_i),
    .slv_aw_valid_i (slv_req_i.aw_valid),
    .slv_ar_valid_i (slv_req_i.ar_valid),
    .mst_aw_ready_i (mst_resp_i.aw_ready),
    .mst_ar_ready_i (mst_resp_i.ar_ready),
    .status_i       (status),
    .gate_o         (gate),
    .isolated_o     (isolated_o)
  );

  // Combinational path between both ports
  bus_gate u_gate (
    .slv_req_i  (slv_req_i),
    .mst_resp_i (mst_resp_i),
    .gate_i     (gate),
    .w_open_i   (status.w_open),
    .mst_req_o  (mst_req_o),
    .slv_resp_o (slv_resp_o)
  );

endmodule

`default_nettype wire

// File: hw/bus_gate.sv
`default_nettype none

module bus_gate (
  input  axi_iso_pkg::axi_req_t   slv_req_i,
  input  axi_iso_pkg::axi_resp_t  mst_resp_i,
  input  axi_iso_pkg::gate_ctrl_t gate_i,
  input  logic                    w_open_i,
  output axi_iso_pkg::axi_req_t   mst_req_o,
  output axi_iso_pkg::axi_resp_t  slv_resp_o
);

  always_comb begin
    // Straight pass-through by default
    mst_req_o  = slv_req_i;
    slv_resp_o = mst_resp_i;

    //////////////////////////////
    // Address channels
    //////////////////////////////

    if (gate_i.aw_cut) begin
      mst_req_o.aw        = '0;
      mst_req_o.aw_valid  = 1'b0;
      slv_resp_o.aw_ready = 1'b0;
    end
    // Keep a started AW visible until it is accepted
    if (gate_i.aw_hold) begin
      mst_req_o.aw_valid = 1'b1;
    end

    if (gate_i.ar_cut) begin
      mst_req_o.ar        = '0;
      mst_req_o.ar_valid  = 1'b0;
      slv_resp_o.ar_ready = 1'b0;
    end
    if (gate_i.ar_hold) begin
      mst_req_o.ar_valid = 1'b1;
    end

    //////////////////////////////
    // Write data
    //////////////////////////////

    // No open burst means no W beat may pass
    if (!w_open_i) begin
      mst_req_o.w        = '0;
      mst_req_o.w_valid  = 1'b0;
      slv_resp_o.w_ready = 1'b0;
    end

    //////////////////////////////
    // Responses
    //////////////////////////////

    if (gate_i.b_cut) begin
      slv_resp_o.b       = '0;
      slv_resp_o.b_valid = 1'b0;
      mst_req_o.b_ready  = 1'b0;
    end
    if (gate_i.r_cut) begin
      slv_resp_o.r       = '0;
      slv_resp_o.r_valid = 1'b0;
      mst_req_o.r_ready  = 1'b0;
    end

    // Fully isolated, downstream sees nothing at all
    if (gate_i.req_mute) begin
      mst_req_o = '0;
    end
  end

endmodule

`default_nettype wire

// File: hw/pending_tracker.sv
`default_nettype none

module pending_tracker (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  axi_iso_pkg::axi_req_t     mst_req_i,
  input  axi_iso_pkg::axi_resp_t    mst_resp_i,
  output axi_iso_pkg::pend_status_t status_o
);

  // Up/down step shared by all three counters
  function automatic axi_iso_pkg::cnt_t step(
    input axi_iso_pkg::cnt_t cnt,
    input logic              inc,
    input logic              dec
  );
    axi_iso_pkg::cnt_t nxt;
    nxt = cnt;
    if (inc && !dec) begin
      nxt = cnt + axi_iso_pkg::cnt_t'(1);
    end else if (dec && !inc) begin
      nxt = cnt - axi_iso_pkg::cnt_t'(1);
    end
    return nxt;
  endfunction

  //////////////////////////////
  // Downstream handshakes
  //////////////////////////////

  logic aw_hs;
  logic w_last_hs;
  logic b_hs;
  logic ar_hs;
  logic r_last_hs;

  assign aw_hs     = mst_req_i.aw_valid & mst_resp_i.aw_ready;
  // Only the closing beat ends a burst
  assign w_last_hs = mst_req_i.w_valid & mst_resp_i.w_ready & mst_req_i.w.last;
  assign b_hs      = mst_resp_i.b_valid & mst_req_i.b_ready;
  assign ar_hs     = mst_req_i.ar_valid & mst_resp_i.ar_ready;
  assign r_last_hs = mst_resp_i.r_valid & mst_req_i.r_ready & mst_resp_i.r.last;

  //////////////////////////////
  // Counters
  //////////////////////////////

  axi_iso_pkg::cnt_t aw_cnt_q;
  axi_iso_pkg::cnt_t w_cnt_q;
  axi_iso_pkg::cnt_t ar_cnt_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      aw_cnt_q <= '0;
      w_cnt_q  <= '0;
      ar_cnt_q <= '0;
    end else begin
      // Open writes, closed by B
      aw_cnt_q <= step(aw_cnt_q, aw_hs, b_hs);
      // Open W bursts, closed by the last beat
      w_cnt_q  <= step(w_cnt_q, aw_hs, w_last_hs);
      // Open reads, closed by the last R beat
      ar_cnt_q <= step(ar_cnt_q, ar_hs, r_last_hs);
    end
  end

  //////////////////////////////
  // Status flags
  //////////////////////////////

  always_comb begin
    status_o.aw_full = (aw_cnt_q >= axi_iso_pkg::cnt_t'(axi_iso_pkg::NUM_PENDING));
    status_o.w_full  = (w_cnt_q >= axi_iso_pkg::cnt_t'(axi_iso_pkg::NUM_PENDING));
    status_o.ar_full = (ar_cnt_q >= axi_iso_pkg::cnt_t'(axi_iso_pkg::NUM_PENDING));
    status_o.aw_zero = (aw_cnt_q == '0);
    status_o.ar_zero = (ar_cnt_q == '0);
    // AW in this cycle already opens W, data may ride along with it
    status_o.w_open  = (w_cnt_q != '0) | aw_hs;
  end

endmodule

`default_nettype wire

// File: hw/iso_ctrl.sv
`default_nettype none

module iso_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      isolate_i,
  input  logic                      slv_aw_valid_i,
  input  logic                      slv_ar_valid_i,
  input  logic                      mst_aw_ready_i,
  input  logic                      mst_ar_ready_i,
  input  axi_iso_pkg::pend_status_t status_i,
  output axi_iso_pkg::gate_ctrl_t   gate_o,
  output logic                      isolated_o
);

  //////////////////////////////
  // Shared path transition
  //////////////////////////////

  // Same rules apply to the AW and the AR path
  function automatic axi_iso_pkg::iso_state_e next_state(
    input axi_iso_pkg::iso_state_e cur,
    input logic                    iso,
    input logic                    full,
    input logic                    valid,
    input logic                    ready,
    input logic                    zero
  );
    axi_iso_pkg::iso_state_e nxt;
    nxt = cur;
    case (cur)
      axi_iso_pkg::ST_NORMAL: begin
        if (full) begin
          // Address is blocked, nothing to hold
          if (iso) nxt = axi_iso_pkg::ST_DRAIN;
        end else if (valid && !ready) begin
          // Valid went out downstream, keep it until accepted
          nxt = axi_iso_pkg::ST_HOLD;
        end else if (iso) begin
          nxt = axi_iso_pkg::ST_DRAIN;
        end
      end
      axi_iso_pkg::ST_HOLD: begin
        // Leave on the edge where the handshake completes
        if (ready) nxt = iso ? axi_iso_pkg::ST_DRAIN : axi_iso_pkg::ST_NORMAL;
      end
      axi_iso_pkg::ST_DRAIN: begin
        // Wait for the open count to reach zero
        if (zero) nxt = axi_iso_pkg::ST_ISOLATE;
      end
      axi_iso_pkg::ST_ISOLATE: begin
        if (!iso) nxt = axi_iso_pkg::ST_NORMAL;
      end
      default: nxt = axi_iso_pkg::ST_ISOLATE;
    endcase
    return nxt;
  endfunction

  //////////////////////////////
  // State registers
  //////////////////////////////

  axi_iso_pkg::iso_state_e aw_state_q;
  axi_iso_pkg::iso_state_e ar_state_q;
  axi_iso_pkg::iso_state_e aw_state_d;
  axi_iso_pkg::iso_state_e ar_state_d;

  logic wr_full;
  logic aw_iso;
  logic ar_iso;

  // Write path also stops on a full burst count
  assign wr_full = status_i.aw_full | status_i.w_full;

  assign aw_state_d = next_state(aw_state_q, isolate_i, wr_full, slv_aw_valid_i,
                                 mst_aw_ready_i, status_i.aw_zero);
  assign ar_state_d = next_state(ar_state_q, isolate_i, status_i.ar_full, slv_ar_valid_i,
                                 mst_ar_ready_i, status_i.ar_zero);

  // Come out of reset isolated
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      aw_state_q <= axi_iso_pkg::ST_ISOLATE;
      ar_state_q <= axi_iso_pkg::ST_ISOLATE;
    end else begin
      aw_state_q <= aw_state_d;
      ar_state_q <= ar_state_d;
    end
  end

  //////////////////////////////
  // Gate commands
  //////////////////////////////

  assign aw_iso = (aw_state_q == axi_iso_pkg::ST_ISOLATE);
  assign ar_iso = (ar_state_q == axi_iso_pkg::ST_ISOLATE);

  always_comb begin
    // Address cut on back-pressure, while draining and while isolated
    gate_o.aw_cut   = ((aw_state_q == axi_iso_pkg::ST_NORMAL) && wr_full) ||
                      (aw_state_q == axi_iso_pkg::ST_DRAIN) || aw_iso;
    gate_o.ar_cut   = ((ar_state_q == axi_iso_pkg::ST_NORMAL) && status_i.ar_full) ||
                      (ar_state_q == axi_iso_pkg::ST_DRAIN) || ar_iso;
    // Pending address stays valid downstream
    gate_o.aw_hold  = (aw_state_q == axi_iso_pkg::ST_HOLD);
    gate_o.ar_hold  = (ar_state_q == axi_iso_pkg::ST_HOLD);
    // Responses only blocked once fully isolated
    gate_o.b_cut    = aw_iso;
    gate_o.r_cut    = ar_iso;
    gate_o.req_mute = aw_iso & ar_iso;
  end

  assign isolated_o = aw_iso & ar_iso;

endmodule

`default_nettype wire

// File: hw/axi_iso_pkg.sv
`default_nettype none

package axi_iso_pkg;

  //////////////////////////////
  // Widths and limits
  //////////////////////////////

  localparam int ID_W   = 4;
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // Max open transactions per counter
  localparam int NUM_PENDING = 4;
  // Must hold the value NUM_PENDING itself
  localparam int CNT_W = $clog2(NUM_PENDING + 1);

  typedef logic [CNT_W-1:0] cnt_t;

  //////////////////////////////
  // AXI channel payloads
  //////////////////////////////

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
    logic [1:0]        burst;
  } aw_chan_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } w_chan_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } b_chan_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
    logic [1:0]        burst;
  } ar_chan_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
    logic              last;
  } r_chan_t;

  // Manager to subordinate direction
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Subordinate to manager direction
  typedef struct packed {
    logic    aw_ready;
    logic    ar_ready;
    logic    w_ready;
    logic    b_valid;
    b_chan_t b;
    logic    r_valid;
    r_chan_t r;
  } axi_resp_t;

  //////////////////////////////
  // Isolation control
  //////////////////////////////

  // Per-path state, write path and read path each own one
  typedef enum logic [1:0] {
    ST_NORMAL,
    ST_HOLD,
    ST_DRAIN,
    ST_ISOLATE
  } iso_state_e;

  typedef struct packed {
    logic aw_full;
    logic w_full;
    logic ar_full;
    logic aw_zero;
    logic ar_zero;
    logic w_open;
  } pend_status_t;

  typedef struct packed {
    logic aw_cut;
    logic ar_cut;
    logic aw_hold;
    logic ar_hold;
    logic b_cut;
    logic r_cut;
    logic req_mute;
  } gate_ctrl_t;

endpackage

`default_nettype wire
